// File: mem_isa_pkg.sv
/*
 * Memory stage ISA definitions
 * Operation kinds, access sizes, data widths and the queue entry format
 */

package mem_isa_pkg;

    ////////////////////////////////////////////////////////////////////
    // Data widths
    ////////////////////////////////////////////////////////////////////

    typedef logic [63:0] bus64_t;   // Data or address word
    typedef logic [4:0]  reg_t;     // Destination register index

    ////////////////////////////////////////////////////////////////////
    // Operation encodings
    ////////////////////////////////////////////////////////////////////

    // Kind of memory operation
    typedef enum logic [1:0] {
        NOP   = 2'b00,  // Retired without touching the cache
        LOAD  = 2'b01,
        STORE = 2'b10
    } instr_type_t;

    // Access granularity, zero-extended on loads
    typedef enum logic [1:0] {
        BYTE  = 2'b00,
        HALF  = 2'b01,
        WORD  = 2'b10,
        DWORD = 2'b11
    } mem_size_t;

    // One pending operation in the load/store queue
    typedef struct packed {
        logic        valid;
        bus64_t      addr;
        bus64_t      data;          // Store data, unused for loads
        instr_type_t instr_type;
        mem_size_t   mem_size;
        reg_t        rd;            // Load destination
    } lsq_entry_t;

endpackage

// File: mem_cfg_pkg.sv
/*
 * Memory stage sizing
 * Queue depth, bank count, address slicing and bank timing
 */

package mem_cfg_pkg;

    // Load/store queue
    localparam int LSQ_DEPTH    = 8;
    localparam int LSQ_IDX_W    = 3;

    // Bank selection from address bits 4..3
    localparam int NUM_BANKS    = 4;
    localparam int BANK_SEL_LSB = 3;
    localparam int BANK_SEL_W   = $clog2(NUM_BANKS);

    // Word index inside a bank, address bits 8..5
    localparam int BANK_WORDS   = 16;
    localparam int WORD_IDX_LSB = 5;
    localparam int WORD_IDX_W   = $clog2(BANK_WORDS);

    localparam int BANK_LATENCY = 2;    // Accept to response, in cycles

endpackage

// File: dcache_if.sv
/*
 * Data cache request and response interfaces
 * Request uses a valid/lock handshake, response is a single-cycle pulse
 */

`timescale 1ns/1ps

interface dcache_req_if;
    logic                     valid;        // New memory request
    mem_isa_pkg::bus64_t      addr;
    mem_isa_pkg::bus64_t      data;         // Store data
    mem_isa_pkg::instr_type_t instr_type;
    mem_isa_pkg::mem_size_t   mem_size;
    mem_isa_pkg::reg_t        rd;
    logic                     lock;         // Cache busy, hold request

    // Requester side
    modport master (
        output valid, addr, data, instr_type, mem_size, rd,
        input  lock
    );

    // Cache side
    modport slave (
        input  valid, addr, data, instr_type, mem_size, rd,
        output lock
    );
endinterface

interface dcache_rsp_if;
    logic                valid;     // One-cycle pulse, no back-pressure
    mem_isa_pkg::bus64_t data;      // Loaded data, already zero-extended
    mem_isa_pkg::reg_t   rd;

    modport master (output valid, data, rd);
    modport slave  (input  valid, data, rd);
endinterface

// File: load_store_queue.sv
/*
 * Load/store queue
 * Circular buffer of pending memory operations, drained in program order
 */

`timescale 1ns/1ps

module load_store_queue (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                push_i,     // New operation from the core
    input  mem_isa_pkg::lsq_entry_t             entry_i,
    input  logic                                flush_i,    // Drop every entry
    input  logic                                pop_i,      // Head issued or retired
    output mem_isa_pkg::lsq_entry_t             head_o,
    output logic [mem_cfg_pkg::LSQ_IDX_W-1:0]   head_idx_o, // To graduation logic
    output logic                                full_o
);

    mem_isa_pkg::lsq_entry_t buf_q [mem_cfg_pkg::LSQ_DEPTH];

    logic [mem_cfg_pkg::LSQ_IDX_W-1:0] head_q;
    logic [mem_cfg_pkg::LSQ_IDX_W-1:0] tail_q;
    logic [mem_cfg_pkg::LSQ_IDX_W:0]   count_q;     // One extra bit for full
    logic                              empty;
    logic                              do_push;
    logic                              do_pop;

    assign empty   = (count_q == '0);
    assign full_o  = (count_q == mem_cfg_pkg::LSQ_DEPTH);
    assign do_push = push_i & ~full_o;      // Core must not push while full
    assign do_pop  = pop_i & ~empty;

    ////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;      // Flush wins over push and pop
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) tail_q <= tail_q + 1'b1;  // Wraps at depth
            if (do_pop)  head_q <= head_q + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;       // Both or neither
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (do_push && !flush_i) begin
            buf_q[tail_q] <= entry_i;
        end
    end

    // Head seen from the next cycle after a push
    always_comb begin
        head_o       = buf_q[head_q];
        head_o.valid = buf_q[head_q].valid & ~empty;    // Nothing valid when empty
    end

    assign head_idx_o = head_q;

endmodule

// File: mem_unit.sv
/*
 * Memory unit
 * Issues queue heads to the data cache in order and returns load results
 */

`timescale 1ns/1ps

module mem_unit (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    flush_i,        // Kill queued and pending ops
    input  mem_isa_pkg::lsq_entry_t head_i,         // Queue head
    output logic                    pop_o,
    dcache_req_if.master            req,
    dcache_rsp_if.slave             rsp,
    output logic                    load_valid_o,   // Load result to pipeline
    output mem_isa_pkg::bus64_t     load_data_o,
    output mem_isa_pkg::reg_t       load_rd_o
);

    typedef enum logic [1:0] {
        ResetState   = 2'b00,
        ReadHead     = 2'b01,
        WaitResponse = 2'b10
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   is_mem_op;
    logic   is_load;

    assign is_load   = (head_i.instr_type == mem_isa_pkg::LOAD);
    assign is_mem_op = is_load | (head_i.instr_type == mem_isa_pkg::STORE);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) state_q <= ResetState;
        else         state_q <= state_d;
    end

    ////////////////////////////////////////////////////////////////////
    // Request and next state
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        // Fields follow the head, which stays put until popped
        req.valid      = 1'b0;
        req.addr       = head_i.addr;
        req.data       = head_i.data;
        req.instr_type = head_i.instr_type;
        req.mem_size   = head_i.mem_size;
        req.rd         = head_i.rd;
        pop_o          = 1'b0;
        state_d        = state_q;

        case (state_q)
            ResetState: begin
                state_d = ReadHead;
            end
            ReadHead: begin
                if (!flush_i && head_i.valid) begin
                    if (is_mem_op) begin
                        req.valid = 1'b1;
                        if (!req.lock) begin        // Transfer this cycle
                            pop_o = 1'b1;           // Store retires on accept
                            if (is_load) state_d = WaitResponse;
                        end
                    end else begin
                        pop_o = 1'b1;               // NOP retires here
                    end
                end
            end
            WaitResponse: begin
                // Nothing issued until the load is back
                if (flush_i || rsp.valid) state_d = ReadHead;
            end
            default: begin
                state_d = ResetState;
            end
        endcase
    end

    // Stale responses after a flush arrive in ReadHead and are dropped
    assign load_valid_o = (state_q == WaitResponse) & rsp.valid & ~flush_i;
    assign load_data_o  = rsp.data;
    assign load_rd_o    = rsp.rd;

endmodule

// File: dcache_bank_router.sv
/*
 * Data cache bank router
 * Steers a request to the bank chosen by the address and returns its lock
 */

`timescale 1ns/1ps

module dcache_bank_router (
    dcache_req_if.slave  req,
    dcache_req_if.master bank_req [mem_cfg_pkg::NUM_BANKS]
);

    logic [mem_cfg_pkg::BANK_SEL_W-1:0] sel;
    logic [mem_cfg_pkg::NUM_BANKS-1:0]  lock_vec;

    // Bank from address bits 4..3
    assign sel = req.addr[mem_cfg_pkg::BANK_SEL_LSB +: mem_cfg_pkg::BANK_SEL_W];

    genvar g;
    generate
        for (g = 0; g < mem_cfg_pkg::NUM_BANKS; g++) begin : g_bank
            assign bank_req[g].valid      = req.valid & (sel == g);  // Selected bank only
            assign bank_req[g].addr       = req.addr;
            assign bank_req[g].data       = req.data;
            assign bank_req[g].instr_type = req.instr_type;
            assign bank_req[g].mem_size   = req.mem_size;
            assign bank_req[g].rd         = req.rd;
            assign lock_vec[g]            = bank_req[g].lock;
        end
    endgenerate

    // Only the target bank may stall the master
    assign req.lock = lock_vec[sel];

endmodule

// File: dcache_bank.sv
/*
 * Data cache bank
 * Small doubleword array with lane writes and fixed-latency loads
 */

`timescale 1ns/1ps

module dcache_bank (
    input  logic         clk_i,
    input  logic         rstn_i,
    dcache_req_if.slave  req,
    dcache_rsp_if.master rsp
);

    mem_isa_pkg::bus64_t mem_q [mem_cfg_pkg::BANK_WORDS];

    // Pipeline of in-flight accesses, stage 0 is the youngest
    logic [mem_cfg_pkg::BANK_LATENCY-1:0] busy_q;   // Any accepted request
    logic [mem_cfg_pkg::BANK_LATENCY-1:0] vld_q;    // Loads only
    mem_isa_pkg::bus64_t                  data_q [mem_cfg_pkg::BANK_LATENCY];
    mem_isa_pkg::reg_t                    rd_q   [mem_cfg_pkg::BANK_LATENCY];

    logic [mem_cfg_pkg::WORD_IDX_W-1:0] word_idx;
    logic [5:0]                         shamt;      // Byte offset in bits
    logic                               accept;
    mem_isa_pkg::bus64_t                size_mask;
    mem_isa_pkg::bus64_t                wr_mask;
    mem_isa_pkg::bus64_t                rd_data;

    assign accept   = req.valid & ~req.lock;
    assign word_idx = req.addr[mem_cfg_pkg::WORD_IDX_LSB +: mem_cfg_pkg::WORD_IDX_W];
    assign shamt    = {req.addr[2:0], 3'b000};

    // Lanes covered by the access size
    always_comb begin
        case (req.mem_size)
            mem_isa_pkg::BYTE: size_mask = 64'h0000_0000_0000_00FF;
            mem_isa_pkg::HALF: size_mask = 64'h0000_0000_0000_FFFF;
            mem_isa_pkg::WORD: size_mask = 64'h0000_0000_FFFF_FFFF;
            default:           size_mask = '1;
        endcase
    end

    assign wr_mask = size_mask << shamt;                        // Addressed lanes
    assign rd_data = (mem_q[word_idx] >> shamt) & size_mask;    // Shift down, zero-extend

    ////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < mem_cfg_pkg::BANK_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (accept && req.instr_type == mem_isa_pkg::STORE) begin
            mem_q[word_idx] <= (mem_q[word_idx] & ~wr_mask) | ((req.data << shamt) & wr_mask);
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Latency pipeline
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q <= '0;
            vld_q  <= '0;
        end else begin
            busy_q[0] <= accept;
            vld_q[0]  <= accept & (req.instr_type == mem_isa_pkg::LOAD);
            for (int i = 1; i < mem_cfg_pkg::BANK_LATENCY; i++) begin
                busy_q[i] <= busy_q[i-1];
                vld_q[i]  <= vld_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        data_q[0] <= rd_data;   // Read at accept, stores come first in order
        rd_q[0]   <= req.rd;
        for (int i = 1; i < mem_cfg_pkg::BANK_LATENCY; i++) begin
            data_q[i] <= data_q[i-1];
            rd_q[i]   <= rd_q[i-1];
        end
    end

    assign req.lock  = |busy_q;     // Busy for BANK_LATENCY cycles
    assign rsp.valid = vld_q[mem_cfg_pkg::BANK_LATENCY-1];
    assign rsp.data  = data_q[mem_cfg_pkg::BANK_LATENCY-1];
    assign rsp.rd    = rd_q[mem_cfg_pkg::BANK_LATENCY-1];

endmodule

// File: dcache_response_collector.sv
/*
 * Data cache response collector
 * Picks the bank with a valid response and registers it
 */

`timescale 1ns/1ps

module dcache_response_collector (
    input  logic         clk_i,
    input  logic         rstn_i,
    dcache_rsp_if.slave  bank_rsp [mem_cfg_pkg::NUM_BANKS],
    dcache_rsp_if.master rsp
);

    logic [mem_cfg_pkg::NUM_BANKS-1:0] vld_vec;
    mem_isa_pkg::bus64_t               data_vec [mem_cfg_pkg::NUM_BANKS];
    mem_isa_pkg::reg_t                 rd_vec   [mem_cfg_pkg::NUM_BANKS];
    mem_isa_pkg::bus64_t               sel_data;
    mem_isa_pkg::reg_t                 sel_rd;
    logic                              valid_q;
    mem_isa_pkg::bus64_t               data_q;
    mem_isa_pkg::reg_t                 rd_q;

    genvar g;
    generate
        for (g = 0; g < mem_cfg_pkg::NUM_BANKS; g++) begin : g_flat
            assign vld_vec[g]  = bank_rsp[g].valid;
            assign data_vec[g] = bank_rsp[g].data;
            assign rd_vec[g]   = bank_rsp[g].rd;
        end
    endgenerate

    // In-order issue keeps at most one bank responding
    always_comb begin
        sel_data = '0;
        sel_rd   = '0;
        for (int i = 0; i < mem_cfg_pkg::NUM_BANKS; i++) begin
            if (vld_vec[i]) begin
                sel_data = data_vec[i];
                sel_rd   = rd_vec[i];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) valid_q <= 1'b0;
        else         valid_q <= |vld_vec;
    end

    always_ff @(posedge clk_i) begin
        if (|vld_vec) begin
            data_q <= sel_data;
            rd_q   <= sel_rd;
        end
    end

    assign rsp.valid = valid_q;     // One cycle after the bank
    assign rsp.data  = data_q;
    assign rsp.rd    = rd_q;

endmodule

// File: mem_subsystem_top.sv
/*
 * Memory subsystem top
 * Queue, memory unit and four-bank data cache with router and collector
 */

`timescale 1ns/1ps

module mem_subsystem_top (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic                              instr_valid_i,    // Push into the queue
    input  mem_isa_pkg::bus64_t               instr_addr_i,
    input  mem_isa_pkg::bus64_t               instr_data_i,
    input  mem_isa_pkg::instr_type_t          instr_type_i,
    input  mem_isa_pkg::mem_size_t            instr_size_i,
    input  mem_isa_pkg::reg_t                 instr_rd_i,
    input  logic                              flush_i,
    output logic                              lsq_full_o,
    output logic [mem_cfg_pkg::LSQ_IDX_W-1:0] ls_queue_entry_o,
    output logic                              load_valid_o,
    output mem_isa_pkg::bus64_t               load_data_o,
    output mem_isa_pkg::reg_t                 load_rd_o
);

    mem_isa_pkg::lsq_entry_t new_entry;
    mem_isa_pkg::lsq_entry_t head_entry;
    logic                    pop;

    dcache_req_if cache_req ();
    dcache_rsp_if cache_rsp ();
    dcache_req_if bank_req [mem_cfg_pkg::NUM_BANKS] ();
    dcache_rsp_if bank_rsp [mem_cfg_pkg::NUM_BANKS] ();

    // Pack the instruction ports
    assign new_entry = '{valid:      instr_valid_i,
                         addr:       instr_addr_i,
                         data:       instr_data_i,
                         instr_type: instr_type_i,
                         mem_size:   instr_size_i,
                         rd:         instr_rd_i};

    load_store_queue lsq_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .push_i     (instr_valid_i),
        .entry_i    (new_entry),
        .flush_i    (flush_i),
        .pop_i      (pop),
        .head_o     (head_entry),
        .head_idx_o (ls_queue_entry_o),
        .full_o     (lsq_full_o)
    );

    mem_unit mem_unit_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .flush_i      (flush_i),
        .head_i       (head_entry),
        .pop_o        (pop),
        .req          (cache_req),
        .rsp          (cache_rsp),
        .load_valid_o (load_valid_o),
        .load_data_o  (load_data_o),
        .load_rd_o    (load_rd_o)
    );

    ////////////////////////////////////////////////////////////////////
    // Banked data cache
    ////////////////////////////////////////////////////////////////////

    dcache_bank_router router_inst (
        .req      (cache_req),
        .bank_req (bank_req)
    );

    genvar g;
    generate
        for (g = 0; g < mem_cfg_pkg::NUM_BANKS; g++) begin : g_bank
            dcache_bank bank_inst (
                .clk_i  (clk_i),
                .rstn_i (rstn_i),
                .req    (bank_req[g]),
                .rsp    (bank_rsp[g])
            );
        end
    endgenerate

    dcache_response_collector collector_inst (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .bank_rsp (bank_rsp),
        .rsp      (cache_rsp)
    );

endmodule

// File: mem_subsystem_checker.sv
/*
 * Memory subsystem protocol checker
 * Bound to the top level, flags queue overrun and stray load results
 */

`timescale 1ns/1ps

module mem_subsystem_checker (
    input logic clk_i,
    input logic rstn_i,
    input logic instr_valid_i,
    input logic flush_i,
    input logic lsq_full_o,
    input logic load_valid_o
);

    int unsigned err_cnt = 0;   // Read by the testbench monitor

    // Core must stall while the queue is full
    a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        lsq_full_o |-> !instr_valid_i)
    else begin
        err_cnt++;
        $error("push while the load/store queue is full");
    end

    // One load result per load, never a stretched pulse
    a_single_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        load_valid_o |=> !load_valid_o)
    else begin
        err_cnt++;
        $error("load_valid_o high for two cycles in a row");
    end

    // Killed load must not come back
    a_quiet_after_flush: assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_i |=> !load_valid_o [*3])
    else begin
        err_cnt++;
        $error("load result within three cycles of a flush");
    end

endmodule

bind mem_subsystem_top mem_subsystem_checker chk (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .flush_i       (flush_i),
    .lsq_full_o    (lsq_full_o),
    .load_valid_o  (load_valid_o)
);

// File: tb_mem_subsystem.sv
/*
 * Memory subsystem testbench
 * Random loads and stores against a byte-array reference memory, plus flush
 */

`timescale 1ns/1ps

module tb_mem_subsystem;

    typedef struct {
        mem_isa_pkg::bus64_t data;
        mem_isa_pkg::reg_t   rd;
    } load_result_t;

    localparam int MEM_BYTES     = 512;     // Address bits 8..0 cover all banks
    localparam int SPACE_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 4000;

    logic                              clk_i;
    logic                              rstn_i;
    logic                              instr_valid_i;
    mem_isa_pkg::bus64_t               instr_addr_i;
    mem_isa_pkg::bus64_t               instr_data_i;
    mem_isa_pkg::instr_type_t          instr_type_i;
    mem_isa_pkg::mem_size_t            instr_size_i;
    mem_isa_pkg::reg_t                 instr_rd_i;
    logic                              flush_i;
    logic                              lsq_full_o;
    logic [mem_cfg_pkg::LSQ_IDX_W-1:0] ls_queue_entry_o;
    logic                              load_valid_o;
    mem_isa_pkg::bus64_t               load_data_o;
    mem_isa_pkg::reg_t                 load_rd_o;

    logic [7:0]   ref_mem [MEM_BYTES];  // Reference memory, program order
    load_result_t exp_q [$];            // Loads still owed by the DUT
    logic         saw_full;
    int unsigned  seed_val;
    int           push_cnt;             // Pushes since reset or last flush

    mem_subsystem_top dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic int size_bytes(input mem_isa_pkg::mem_size_t size);
        return 1 << size;   // 1, 2, 4 or 8 lanes
    endfunction

    // Little-endian gather, zero-extended
    function automatic mem_isa_pkg::bus64_t model_read(input int addr,
                                                       input mem_isa_pkg::mem_size_t size);
        mem_isa_pkg::bus64_t val;
        val = '0;
        for (int i = 0; i < size_bytes(size); i++) begin
            val[8*i +: 8] = ref_mem[addr + i];
        end
        return val;
    endfunction

    function automatic int rand_addr(input mem_isa_pkg::mem_size_t size);
        return $urandom_range(MEM_BYTES - 1, 0) & ~(size_bytes(size) - 1);  // Aligned
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    // Call right after a rising edge
    task automatic drive_op(input mem_isa_pkg::instr_type_t kind, input mem_isa_pkg::bus64_t addr,
                            input mem_isa_pkg::bus64_t data, input mem_isa_pkg::mem_size_t size,
                            input mem_isa_pkg::reg_t rd);
        instr_valid_i <= 1'b1;
        instr_type_i  <= kind;
        instr_addr_i  <= addr;
        instr_data_i  <= data;
        instr_size_i  <= size;
        instr_rd_i    <= rd;
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Push with back-pressure and model update
    ///////////////////////////////////////////////////////////////////////

    task automatic send_op(input mem_isa_pkg::instr_type_t kind, input int addr,
                           input mem_isa_pkg::bus64_t data, input mem_isa_pkg::mem_size_t size,
                           input mem_isa_pkg::reg_t rd);
        int           waited;
        load_result_t res;
        waited = 0;
        @(negedge clk_i);
        // Previous push may still be landing, so gap one cycle
        while (lsq_full_o || instr_valid_i) begin
            if (lsq_full_o) saw_full = 1'b1;
            @(posedge clk_i);
            instr_valid_i <= 1'b0;
            @(negedge clk_i);
            waited++;
            if (waited > SPACE_TIMEOUT) begin
                report_failure("Timed out waiting for room in the load/store queue");
            end
        end
        @(posedge clk_i);
        drive_op(kind, addr, data, size, rd);
        push_cnt++;
        if (kind == mem_isa_pkg::STORE) begin
            for (int i = 0; i < size_bytes(size); i++) begin
                ref_mem[addr + i] = data[8*i +: 8];     // Addressed lanes only
            end
        end else if (kind == mem_isa_pkg::LOAD) begin
            res.data = model_read(addr, size);
            res.rd   = rd;
            exp_q.push_back(res);
        end
    endtask

    // Wait for every owed load, then let trailing stores retire
    task automatic drain();
        int                                waited;
        logic [mem_cfg_pkg::LSQ_IDX_W-1:0] want_idx;
        waited = 0;
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                report_failure("Timed out waiting for outstanding load results");
            end
        end
        repeat (32) @(posedge clk_i);
        // Queue empty, head has caught up with every push
        want_idx = push_cnt % mem_cfg_pkg::LSQ_DEPTH;
        @(negedge clk_i);
        assert (ls_queue_entry_o == want_idx)
        else report_failure($sformatf("ERR %0t: queue head index %0d, expected %0d",
                                      $time, ls_queue_entry_o, want_idx));
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Result monitor
    ///////////////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        load_result_t want;
        if (rstn_i) begin
            assert (dut.chk.err_cnt == 0)
            else report_failure("A protocol assertion in the bound checker failed");
            if (load_valid_o) begin
                assert (exp_q.size() != 0)
                else report_failure($sformatf("ERR %0t: load result rd %0d with no load owed",
                                              $time, load_rd_o));
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    assert (load_data_o == want.data && load_rd_o == want.rd)
                    else report_failure($sformatf(
                        "ERR %0t: load got rd %0d data %h, expected rd %0d data %h",
                        $time, load_rd_o, load_data_o, want.rd, want.data));
                end
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Stimulus
    ///////////////////////////////////////////////////////////////////////

    initial begin
        mem_isa_pkg::instr_type_t kind;
        mem_isa_pkg::mem_size_t   size;
        int                       addr;
        int                       sa1;
        int                       sa2;
        seed_val      = $urandom(97);
        rstn_i        = 1'b0;
        instr_valid_i = 1'b0;
        instr_addr_i  = '0;
        instr_data_i  = '0;
        instr_type_i  = mem_isa_pkg::NOP;
        instr_size_i  = mem_isa_pkg::DWORD;
        instr_rd_i    = '0;
        flush_i       = 1'b0;
        saw_full      = 1'b0;
        push_cnt      = 0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (16) @(posedge clk_i);
        rstn_i <= 1'b1;
        repeat (4) @(posedge clk_i);

        // Fresh banks read zero
        for (int b = 0; b < mem_cfg_pkg::NUM_BANKS; b++) begin
            send_op(mem_isa_pkg::LOAD, b*8 + 32*(b+3), '0, mem_isa_pkg::DWORD, 5'(b+1));
        end

        // Doubleword round trip
        send_op(mem_isa_pkg::STORE, 'h148, 64'h0123_4567_89AB_CDEF, mem_isa_pkg::DWORD, '0);
        send_op(mem_isa_pkg::LOAD, 'h148, '0, mem_isa_pkg::DWORD, 5'd10);

        // Sized lane writes over a known pattern, upper data bits are junk
        send_op(mem_isa_pkg::STORE, 'h0A0, 64'h1111_2222_3333_4444, mem_isa_pkg::DWORD, '0);
        send_op(mem_isa_pkg::STORE, 'h0A1, 64'hFFFF_FFFF_FFFF_FF5A, mem_isa_pkg::BYTE, '0);
        send_op(mem_isa_pkg::STORE, 'h0A2, 64'hEEEE_EEEE_EEEE_BEEF, mem_isa_pkg::HALF, '0);
        send_op(mem_isa_pkg::STORE, 'h0A4, 64'hDDDD_DDDD_CAFE_F00D, mem_isa_pkg::WORD, '0);
        send_op(mem_isa_pkg::LOAD, 'h0A0, '0, mem_isa_pkg::DWORD, 5'd11);
        send_op(mem_isa_pkg::LOAD, 'h0A1, '0, mem_isa_pkg::BYTE, 5'd12);
        send_op(mem_isa_pkg::LOAD, 'h0A2, '0, mem_isa_pkg::HALF, 5'd13);
        send_op(mem_isa_pkg::LOAD, 'h0A4, '0, mem_isa_pkg::WORD, 5'd14);

        // Random mix across banks
        for (int n = 0; n < 80; n++) begin
            kind = ($urandom_range(1, 0) == 1) ? mem_isa_pkg::LOAD : mem_isa_pkg::STORE;
            size = mem_isa_pkg::mem_size_t'($urandom_range(3, 0));
            addr = rand_addr(size);
            send_op(kind, addr, {$urandom, $urandom}, size, 5'($urandom_range(31, 1)));
        end

        // Load burst on bank 2 outruns issue and fills the queue
        for (int n = 0; n < 12; n++) begin
            send_op(mem_isa_pkg::LOAD, 16 + 32*n, '0, mem_isa_pkg::DWORD, 5'(n+1));
        end
        drain();

        // Flush with a load in flight and two stores queued behind it
        sa1 = 'h1E8;
        sa2 = 'h0F0;
        @(posedge clk_i);
        drive_op(mem_isa_pkg::LOAD, 'h058, '0, mem_isa_pkg::DWORD, 5'd31);
        @(posedge clk_i);
        drive_op(mem_isa_pkg::STORE, sa1, ~model_read(sa1, mem_isa_pkg::DWORD),
                 mem_isa_pkg::DWORD, '0);
        @(posedge clk_i);
        drive_op(mem_isa_pkg::STORE, sa2, ~model_read(sa2, mem_isa_pkg::DWORD),
                 mem_isa_pkg::DWORD, '0);
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        flush_i       <= 1'b1;
        push_cnt       = 0;     // Pointers restart at entry 0
        @(posedge clk_i);
        flush_i       <= 1'b0;
        repeat (8) @(posedge clk_i);
        send_op(mem_isa_pkg::LOAD, sa1, '0, mem_isa_pkg::DWORD, 5'd20);    // Must be unchanged
        send_op(mem_isa_pkg::LOAD, sa2, '0, mem_isa_pkg::DWORD, 5'd21);
        drain();

        assert (saw_full) else report_failure("The load/store queue never reported full");
        if (dut.chk.err_cnt == 0 && exp_q.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "Run ended with errors");
        end
    end

endmodule

// File: filelist.f
mem_isa_pkg.sv
mem_cfg_pkg.sv
dcache_if.sv
load_store_queue.sv
mem_unit.sv
dcache_bank_router.sv
dcache_bank.sv
dcache_response_collector.sv
mem_subsystem_top.sv
mem_subsystem_checker.sv
tb_mem_subsystem.sv
